//--- logic/fmc_apb_pkg.sv
package fmc_apb_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Address and data widths

	// Ten high pins, sixteen muxed lines and the implicit zero LSB
	localparam int ADDR_BITS = 27;

	typedef logic [ADDR_BITS-1:0] addr_t;

	// One FMC bus beat
	typedef logic [15:0] half_t;

	////////////////////////////////////////////////////////////////////////////
	// Segments

	// Target APB segment, picked by comparing against the 64-bit base
	typedef enum logic {
		SEG_X32,
		SEG_X64
	} segment_t;

	// Halfwords per transfer on each segment
	localparam int X32_HALVES = 2;
	localparam int X64_HALVES = 4;

	// Map a halfword position in the burst to its 16-bit lane in the data word
	// 32-bit order is lanes 0,1
	// 64-bit order is lanes 2,3,0,1 (bits 47:32 go first)
	function automatic logic [1:0] half_lane(segment_t seg, logic [1:0] idx);
		logic [1:0] flip;
		flip = {seg == SEG_X64, 1'b0};
		return idx ^ flip;
	endfunction

endpackage

//--- logic/apb_requester.sv
`timescale 1ns/10ps

module apb_requester #(
	parameter type word_t      = logic [31:0],
	parameter int  STUCK_LIMIT = 255
) (
	input  logic                          apb_x32,
	input  logic                          rst_n,

	// Request from the cycle decoder
	input  logic                          req_valid,
	input  fmc_apb_pkg::addr_t            req_addr,
	input  logic                          req_write,
	input  word_t                         req_wdata,
	input  logic [$bits(word_t)/8-1:0]    req_strb,
	output logic                          busy,
	output logic                          done,
	output word_t                         rdata,

	// APB requester port
	output fmc_apb_pkg::addr_t            paddr,
	output logic                          psel,
	output logic                          penable,
	output logic                          pwrite,
	output word_t                         pwdata,
	output logic [$bits(word_t)/8-1:0]    pstrb,
	input  word_t                         prdata,
	input  logic                          pready
);

	localparam int CNT_BITS = $clog2(STUCK_LIMIT + 1);

	logic [CNT_BITS-1:0] stuck_cnt;
	logic                start;
	logic                finish;
	logic                stuck_hit;

	// New request only lands while idle
	assign start = req_valid && !psel;

	// Access cycle has run too long without pready
	assign stuck_hit = penable && !pready && (stuck_cnt == CNT_BITS'(STUCK_LIMIT - 1));
	assign finish    = (penable && pready) || stuck_hit;

	// Busy spans setup and access, drops with done
	assign busy = psel;

	////////////////////////////////////////////////////////////////////////////
	// Phase control

	always_ff @(posedge apb_x32) begin
		if (!rst_n) begin
			psel      <= 1'b0;
			penable   <= 1'b0;
			done      <= 1'b0;
			stuck_cnt <= '0;
		end else begin
			done <= 1'b0;

			if (start) begin
				// Setup cycle
				psel <= 1'b1;
			end else if (psel && !penable) begin
				// Access cycle, restart the watchdog
				penable   <= 1'b1;
				stuck_cnt <= '0;
			end else if (finish) begin
				psel    <= 1'b0;
				penable <= 1'b0;
				done    <= 1'b1;
			end else if (penable) begin
				stuck_cnt <= stuck_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Address, write data and read data

	always_ff @(posedge apb_x32) begin
		if (start) begin
			paddr  <= req_addr;
			pwrite <= req_write;
			pwdata <= req_wdata;
			pstrb  <= req_strb;
		end

		// Aborted reads come back as zero
		if (penable && pready)
			rdata <= prdata;
		else if (stuck_hit)
			rdata <= '0;
	end

endmodule

//--- logic/fmc_cycle_decode.sv
`timescale 1ns/10ps

module fmc_cycle_decode #(
	parameter fmc_apb_pkg::addr_t BASE_X64 = 27'h0800000
) (
	input  logic                  apb_x32,
	input  logic                  rst_n,

	// Host bus
	input  logic                  fmc_cs_n,
	input  logic                  fmc_nl_nadv,
	input  logic                  fmc_nwe,
	input  logic [1:0]            fmc_nbl,
	input  logic [9:0]            fmc_a_hi,
	input  fmc_apb_pkg::half_t    fmc_ad_in,
	output logic                  fmc_nwait,

	// Requester status
	input  logic                  busy_x32,
	input  logic                  busy_x64,

	// Request to the requesters
	output logic                  req_valid_x32,
	output logic                  req_valid_x64,
	output fmc_apb_pkg::addr_t    req_addr,
	output logic                  req_write,
	output logic [63:0]           req_wdata,
	output logic [7:0]            req_strb,

	// Read return handshake
	input  logic                  rd_ready,
	output logic                  rd_pending,
	output fmc_apb_pkg::segment_t rd_seg,
	output logic                  rd_advance
);

	localparam int IDX_BITS = $clog2(fmc_apb_pkg::X64_HALVES);

	typedef enum logic [2:0] {
		ST_ADDR,
		ST_WAIT,
		ST_WDATA,
		ST_RD_WAIT,
		ST_RD_DATA,
		ST_END
	} state_t;

	state_t              state;
	logic [IDX_BITS-1:0] half_cnt;
	logic [IDX_BITS-1:0] last_half;
	logic [1:0]          lane;
	fmc_apb_pkg::addr_t  addr_next;
	logic                busy_any;
	logic                addr_cycle;
	logic                take_half;

	////////////////////////////////////////////////////////////////////////////
	// Decode helpers

	// LSB is always zero on a 16-bit bus
	assign addr_next = {fmc_a_hi, fmc_ad_in, 1'b0};

	assign busy_any   = busy_x32 || busy_x64;
	assign addr_cycle = (state == ST_ADDR) && !fmc_cs_n && !fmc_nl_nadv;

	// Write beat accepted on this edge
	assign take_half = (state == ST_WDATA) && !fmc_cs_n && !busy_any;

	// rd_seg holds the segment of the current cycle, reads and writes alike
	assign last_half = (rd_seg == fmc_apb_pkg::SEG_X64) ?
		IDX_BITS'(fmc_apb_pkg::X64_HALVES - 1) :
		IDX_BITS'(fmc_apb_pkg::X32_HALVES - 1);

	assign lane = fmc_apb_pkg::half_lane(rd_seg, half_cnt);

	assign rd_pending = (state == ST_RD_WAIT) || (state == ST_RD_DATA);
	assign rd_advance = (state == ST_RD_DATA);

	////////////////////////////////////////////////////////////////////////////
	// Wait line back to the host

	always_comb begin
		fmc_nwait = 1'b1;
		if (!fmc_cs_n) begin
			case (state)
				// Hold off the first write beat while the last transfer drains
				ST_ADDR, ST_WDATA: fmc_nwait = !busy_any;
				ST_WAIT, ST_RD_WAIT: fmc_nwait = 1'b0;
				default: fmc_nwait = 1'b1;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Cycle FSM

	always_ff @(posedge apb_x32) begin
		if (!rst_n) begin
			state         <= ST_ADDR;
			half_cnt      <= '0;
			req_valid_x32 <= 1'b0;
			req_valid_x64 <= 1'b0;
		end else begin
			// Request strobes last one cycle
			req_valid_x32 <= 1'b0;
			req_valid_x64 <= 1'b0;

			if (fmc_cs_n) begin
				// Deselect always returns to idle
				state    <= ST_ADDR;
				half_cnt <= '0;
			end else begin
				case (state)
					ST_ADDR: begin
						if (!fmc_nl_nadv) begin
							half_cnt <= '0;
							state    <= fmc_nwe ? ST_WAIT : ST_WDATA;
						end
					end

					// Read dispatch once both segments are idle
					ST_WAIT: begin
						if (!busy_any) begin
							if (rd_seg == fmc_apb_pkg::SEG_X64)
								req_valid_x64 <= 1'b1;
							else
								req_valid_x32 <= 1'b1;
							state <= ST_RD_WAIT;
						end
					end

					ST_WDATA: begin
						if (take_half) begin
							half_cnt <= half_cnt + 1'b1;
							// Last beat, fire the write
							if (half_cnt == last_half) begin
								if (rd_seg == fmc_apb_pkg::SEG_X64)
									req_valid_x64 <= 1'b1;
								else
									req_valid_x32 <= 1'b1;
								state <= ST_END;
							end
						end
					end

					ST_RD_WAIT: begin
						if (rd_ready)
							state <= ST_RD_DATA;
					end

					// One halfword per cycle, no gaps
					ST_RD_DATA: begin
						half_cnt <= half_cnt + 1'b1;
						if (half_cnt == last_half)
							state <= ST_END;
					end

					// Ignore the bus until CS# rises
					default: begin
					end
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Address latch and write assembly

	always_ff @(posedge apb_x32) begin
		if (addr_cycle) begin
			req_addr  <= addr_next;
			req_write <= !fmc_nwe;
			rd_seg    <= (addr_next >= BASE_X64) ?
				fmc_apb_pkg::SEG_X64 : fmc_apb_pkg::SEG_X32;
		end

		// Byte lane enables are active low on the pins
		if (take_half) begin
			req_wdata[16*lane +: 16] <= fmc_ad_in;
			req_strb[2*lane +: 2]    <= ~fmc_nbl;
		end
	end

endmodule

//--- logic/fmc_read_return.sv
`timescale 1ns/10ps

module fmc_read_return (
	input  logic                  apb_x32,
	input  logic                  rst_n,

	// Completions from both requesters
	input  logic                  done_x32,
	input  logic [31:0]           rdata_x32,
	input  logic                  done_x64,
	input  logic [63:0]           rdata_x64,

	// Handshake with the cycle decoder
	input  logic                  rd_pending,
	input  fmc_apb_pkg::segment_t rd_seg,
	input  logic                  rd_advance,
	output logic                  rd_ready,

	// Read beat to the host
	output fmc_apb_pkg::half_t    fmc_ad_out
);

	localparam int IDX_BITS = $clog2(fmc_apb_pkg::X64_HALVES);

	logic [63:0]         rd_data_q;
	logic [IDX_BITS-1:0] half_idx;
	logic [IDX_BITS-1:0] last_half;
	logic [1:0]          lane;
	logic                seg_done;
	logic                capture;

	// Only the segment the read went to counts
	assign seg_done = (rd_seg == fmc_apb_pkg::SEG_X64) ? done_x64 : done_x32;
	assign capture  = rd_pending && !rd_ready && seg_done;

	assign last_half = (rd_seg == fmc_apb_pkg::SEG_X64) ?
		IDX_BITS'(fmc_apb_pkg::X64_HALVES - 1) :
		IDX_BITS'(fmc_apb_pkg::X32_HALVES - 1);

	////////////////////////////////////////////////////////////////////////////
	// Ready flag and beat index

	always_ff @(posedge apb_x32) begin
		if (!rst_n || !rd_pending) begin
			rd_ready <= 1'b0;
			half_idx <= '0;
		end else begin
			if (capture)
				rd_ready <= 1'b1;
			// Park on the last beat
			if (rd_advance && half_idx != last_half)
				half_idx <= half_idx + 1'b1;
		end
	end

	// Zero-extend 32-bit data, lanes 2 and 3 are never selected for it
	always_ff @(posedge apb_x32) begin
		if (capture)
			rd_data_q <= (rd_seg == fmc_apb_pkg::SEG_X64) ? rdata_x64 : {32'h0, rdata_x32};
	end

	////////////////////////////////////////////////////////////////////////////
	// Beat mux, same lane order as writes

	assign lane       = fmc_apb_pkg::half_lane(rd_seg, half_idx);
	assign fmc_ad_out = rd_data_q[16*lane +: 16];

endmodule

//--- logic/fmc_apb_bridge.sv
`timescale 1ns/10ps

module fmc_apb_bridge #(
	parameter fmc_apb_pkg::addr_t BASE_X64    = 27'h0800000,
	parameter int                 STUCK_LIMIT = 255
) (
	input  logic               apb_x32,
	input  logic               rst_n,

	// FMC host pins, pad buffer split into in/out/oe
	input  logic               fmc_cs_n,
	input  logic               fmc_nl_nadv,
	input  logic               fmc_nwe,
	input  logic [1:0]         fmc_nbl,
	input  logic [9:0]         fmc_a_hi,
	input  fmc_apb_pkg::half_t fmc_ad_in,
	output fmc_apb_pkg::half_t fmc_ad_out,
	output logic               fmc_ad_oe,
	output logic               fmc_nwait,

	// 32-bit APB segment
	output fmc_apb_pkg::addr_t x32_paddr,
	output logic               x32_psel,
	output logic               x32_penable,
	output logic               x32_pwrite,
	output logic [31:0]        x32_pwdata,
	output logic [3:0]         x32_pstrb,
	input  logic [31:0]        x32_prdata,
	input  logic               x32_pready,

	// 64-bit APB segment
	output fmc_apb_pkg::addr_t x64_paddr,
	output logic               x64_psel,
	output logic               x64_penable,
	output logic               x64_pwrite,
	output logic [63:0]        x64_pwdata,
	output logic [7:0]         x64_pstrb,
	input  logic [63:0]        x64_prdata,
	input  logic               x64_pready
);

	logic                  req_valid_x32;
	logic                  req_valid_x64;
	fmc_apb_pkg::addr_t    req_addr;
	logic                  req_write;
	logic [63:0]           req_wdata;
	logic [7:0]            req_strb;
	logic                  busy_x32;
	logic                  busy_x64;
	logic                  done_x32;
	logic                  done_x64;
	logic [31:0]           rdata_x32;
	logic [63:0]           rdata_x64;
	logic                  rd_pending;
	logic                  rd_ready;
	logic                  rd_advance;
	fmc_apb_pkg::segment_t rd_seg;

	// Drive the AD lines whenever the host reads from this bank
	assign fmc_ad_oe = !fmc_cs_n && fmc_nwe;

	////////////////////////////////////////////////////////////////////////////
	// FMC side

	fmc_cycle_decode #(
		.BASE_X64(BASE_X64)
	) u_decode (
		.apb_x32(apb_x32),
		.rst_n(rst_n),
		.fmc_cs_n(fmc_cs_n),
		.fmc_nl_nadv(fmc_nl_nadv),
		.fmc_nwe(fmc_nwe),
		.fmc_nbl(fmc_nbl),
		.fmc_a_hi(fmc_a_hi),
		.fmc_ad_in(fmc_ad_in),
		.fmc_nwait(fmc_nwait),
		.busy_x32(busy_x32),
		.busy_x64(busy_x64),
		.req_valid_x32(req_valid_x32),
		.req_valid_x64(req_valid_x64),
		.req_addr(req_addr),
		.req_write(req_write),
		.req_wdata(req_wdata),
		.req_strb(req_strb),
		.rd_ready(rd_ready),
		.rd_pending(rd_pending),
		.rd_seg(rd_seg),
		.rd_advance(rd_advance)
	);

	fmc_read_return u_return (
		.apb_x32(apb_x32),
		.rst_n(rst_n),
		.done_x32(done_x32),
		.rdata_x32(rdata_x32),
		.done_x64(done_x64),
		.rdata_x64(rdata_x64),
		.rd_pending(rd_pending),
		.rd_seg(rd_seg),
		.rd_advance(rd_advance),
		.rd_ready(rd_ready),
		.fmc_ad_out(fmc_ad_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// APB segments

	// 32-bit segment takes the low half of the assembled word
	apb_requester #(
		.word_t(logic [31:0]),
		.STUCK_LIMIT(STUCK_LIMIT)
	) u_req_x32 (
		.apb_x32(apb_x32),
		.rst_n(rst_n),
		.req_valid(req_valid_x32),
		.req_addr(req_addr),
		.req_write(req_write),
		.req_wdata(req_wdata[31:0]),
		.req_strb(req_strb[3:0]),
		.busy(busy_x32),
		.done(done_x32),
		.rdata(rdata_x32),
		.paddr(x32_paddr),
		.psel(x32_psel),
		.penable(x32_penable),
		.pwrite(x32_pwrite),
		.pwdata(x32_pwdata),
		.pstrb(x32_pstrb),
		.prdata(x32_prdata),
		.pready(x32_pready)
	);

	apb_requester #(
		.word_t(logic [63:0]),
		.STUCK_LIMIT(STUCK_LIMIT)
	) u_req_x64 (
		.apb_x32(apb_x32),
		.rst_n(rst_n),
		.req_valid(req_valid_x64),
		.req_addr(req_addr),
		.req_write(req_write),
		.req_wdata(req_wdata),
		.req_strb(req_strb),
		.busy(busy_x64),
		.done(done_x64),
		.rdata(rdata_x64),
		.paddr(x64_paddr),
		.psel(x64_psel),
		.penable(x64_penable),
		.pwrite(x64_pwrite),
		.pwdata(x64_pwdata),
		.pstrb(x64_pstrb),
		.prdata(x64_prdata),
		.pready(x64_pready)
	);

endmodule

//--- verif/apb_mem_completer.sv
`timescale 1ns/10ps

module apb_mem_completer #(
	parameter int          DATA_W = 32,
	parameter logic [31:0] SEED   = 32'h0
) (
	input  logic                apb_x32,
	input  logic                rst_n,

	// Holds pready low while set
	input  logic                stall,

	// APB completer port
	input  fmc_apb_pkg::addr_t  paddr,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [DATA_W-1:0]   pwdata,
	input  logic [DATA_W/8-1:0] pstrb,
	output logic [DATA_W-1:0]   prdata,
	output logic                pready
);

	localparam int NBYTES = DATA_W / 8;

	// Sparse byte store where unwritten bytes read as the fill pattern
	logic [7:0]         mem [fmc_apb_pkg::addr_t];
	integer             seed = SEED ^ DATA_W;
	int                 waits;
	fmc_apb_pkg::addr_t base;

	// Word aligned base address
	assign base = paddr & ~fmc_apb_pkg::addr_t'(NBYTES - 1);

	// Every address bit folds into the byte
	function automatic logic [7:0] fill_byte(fmc_apb_pkg::addr_t a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {5'b0, a[26:24]} ^ 8'h3c;
	endfunction

	function automatic logic [DATA_W-1:0] read_word(fmc_apb_pkg::addr_t a);
		logic [DATA_W-1:0]  w;
		fmc_apb_pkg::addr_t b;
		for (int i = 0; i < NBYTES; i++) begin
			b = fmc_apb_pkg::addr_t'(a + i);
			w[8*i +: 8] = mem.exists(b) ? mem[b] : fill_byte(b);
		end
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Transfer handling

	always @(posedge apb_x32) begin
		if (!rst_n || !psel) begin
			pready <= 1'b0;
			prdata <= '0;
		end else if (!penable) begin
			// Setup cycle picks 0 to 3 wait cycles and fetches the word
			waits = $random(seed) & 3;
			prdata <= read_word(base);
			pready <= (waits == 0) && !stall;
		end else if (pready) begin
			// Access ends on this edge
			pready <= 1'b0;
			if (pwrite) begin
				for (int i = 0; i < NBYTES; i++) begin
					if (pstrb[i])
						mem[fmc_apb_pkg::addr_t'(base + i)] = pwdata[8*i +: 8];
				end
			end
		end else if (!stall) begin
			if (waits <= 1)
				pready <= 1'b1;
			else
				waits = waits - 1;
		end
	end

endmodule

//--- verif/fmc_apb_bridge_tb.sv
`timescale 1ns/10ps

module fmc_apb_bridge_tb;

	localparam logic [31:0]        SEED         = 32'he218_b19f;
	localparam fmc_apb_pkg::addr_t BASE_X64     = 27'h0800000;
	localparam int                 STUCK_LIMIT  = 32;
	localparam int                 RESET_CYCLES = 10;
	// 200 transactions at 60 cycles each plus reset
	localparam int                 CYCLE_LIMIT  = 200 * 60 + RESET_CYCLES;

	logic               apb_x32 = 1'b0;
	logic               rst_n;
	logic               fmc_cs_n;
	logic               fmc_nl_nadv;
	logic               fmc_nwe;
	logic [1:0]         fmc_nbl;
	logic [9:0]         fmc_a_hi;
	fmc_apb_pkg::half_t fmc_ad_in;
	fmc_apb_pkg::half_t fmc_ad_out;
	logic               fmc_ad_oe;
	logic               fmc_nwait;
	fmc_apb_pkg::addr_t x32_paddr;
	logic               x32_psel;
	logic               x32_penable;
	logic               x32_pwrite;
	logic [31:0]        x32_pwdata;
	logic [3:0]         x32_pstrb;
	logic [31:0]        x32_prdata;
	logic               x32_pready;
	fmc_apb_pkg::addr_t x64_paddr;
	logic               x64_psel;
	logic               x64_penable;
	logic               x64_pwrite;
	logic [63:0]        x64_pwdata;
	logic [7:0]         x64_pstrb;
	logic [63:0]        x64_prdata;
	logic               x64_pready;
	logic               stall_x32;
	logic               stall_x64;

	// Reference memory with one byte map per segment
	logic [7:0]         mem_x32 [fmc_apb_pkg::addr_t];
	logic [7:0]         mem_x64 [fmc_apb_pkg::addr_t];

	// Address and direction of the latest setup cycle per segment
	fmc_apb_pkg::addr_t setup_addr_x32;
	fmc_apb_pkg::addr_t setup_addr_x64;
	logic               setup_write_x32;
	logic               setup_write_x64;

	integer             seed = SEED;
	int                 test_num;
	int                 checks;
	int                 errors;
	int                 mark_checks;
	int                 mark_errors;
	int                 cycle_cnt;
	fmc_apb_pkg::addr_t addr_a;
	fmc_apb_pkg::addr_t addr_b;
	logic [63:0]        data_a;
	logic [63:0]        data_b;
	logic               swap;

	always #4 apb_x32 = ~apb_x32;

	fmc_apb_bridge #(
		.STUCK_LIMIT(STUCK_LIMIT)
	) UUT (
		.apb_x32(apb_x32), .rst_n(rst_n),
		.fmc_cs_n(fmc_cs_n), .fmc_nl_nadv(fmc_nl_nadv), .fmc_nwe(fmc_nwe),
		.fmc_nbl(fmc_nbl), .fmc_a_hi(fmc_a_hi), .fmc_ad_in(fmc_ad_in),
		.fmc_ad_out(fmc_ad_out), .fmc_ad_oe(fmc_ad_oe), .fmc_nwait(fmc_nwait),
		.x32_paddr(x32_paddr), .x32_psel(x32_psel), .x32_penable(x32_penable),
		.x32_pwrite(x32_pwrite), .x32_pwdata(x32_pwdata), .x32_pstrb(x32_pstrb),
		.x32_prdata(x32_prdata), .x32_pready(x32_pready),
		.x64_paddr(x64_paddr), .x64_psel(x64_psel), .x64_penable(x64_penable),
		.x64_pwrite(x64_pwrite), .x64_pwdata(x64_pwdata), .x64_pstrb(x64_pstrb),
		.x64_prdata(x64_prdata), .x64_pready(x64_pready)
	);

	apb_mem_completer #(.DATA_W(32), .SEED(SEED)) u_mem_x32 (
		.apb_x32(apb_x32), .rst_n(rst_n), .stall(stall_x32),
		.paddr(x32_paddr), .psel(x32_psel), .penable(x32_penable),
		.pwrite(x32_pwrite), .pwdata(x32_pwdata), .pstrb(x32_pstrb),
		.prdata(x32_prdata), .pready(x32_pready)
	);

	apb_mem_completer #(.DATA_W(64), .SEED(SEED)) u_mem_x64 (
		.apb_x32(apb_x32), .rst_n(rst_n), .stall(stall_x64),
		.paddr(x64_paddr), .psel(x64_psel), .penable(x64_penable),
		.pwrite(x64_pwrite), .pwdata(x64_pwdata), .pstrb(x64_pstrb),
		.prdata(x64_prdata), .pready(x64_pready)
	);

	////////////////////////////////////////////////////////////////////////////
	// Run limit

	always @(posedge apb_x32) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			$display("Run timed out, tests still busy after %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// APB setup capture

	always @(posedge apb_x32) begin
		if (x32_psel && !x32_penable) begin
			setup_addr_x32  <= x32_paddr;
			setup_write_x32 <= x32_pwrite;
		end
		if (x64_psel && !x64_penable) begin
			setup_addr_x64  <= x64_paddr;
			setup_write_x64 <= x64_pwrite;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	// Same fold as the completer uses for bytes never written
	function automatic logic [7:0] fill_byte(fmc_apb_pkg::addr_t a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {5'b0, a[26:24]} ^ 8'h3c;
	endfunction

	function automatic logic [7:0] model_byte(fmc_apb_pkg::addr_t a);
		if (a >= BASE_X64)
			return mem_x64.exists(a) ? mem_x64[a] : fill_byte(a);
		return mem_x32.exists(a) ? mem_x32[a] : fill_byte(a);
	endfunction

	task automatic store_byte(fmc_apb_pkg::addr_t a, logic [7:0] v);
		if (a >= BASE_X64)
			mem_x64[a] = v;
		else
			mem_x32[a] = v;
	endtask

	// Lane of the k-th halfword
	// 64-bit bursts start at bits 47:32
	function automatic int lane_of(logic is64, int k);
		if (is64)
			return (k + 2) % 4;
		return k;
	endfunction

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	// Small window per segment so reads hit earlier writes
	function automatic fmc_apb_pkg::addr_t rand_addr(logic is64);
		logic [5:0] slot;
		slot = 6'($random(seed));
		if (is64)
			return BASE_X64 + {18'h0, slot, 3'b000};
		return {19'h0, slot, 2'b00};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and report

	task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic test_done(string name);
		test_num++;
		$display("Test %0d %s finished: %0d checks, %0d errors", test_num, name,
			checks - mark_checks, errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	task automatic idle_checks();
		check_value("fmc_nwait idle", fmc_nwait, 1'b1);
		check_value("x32_psel idle", x32_psel, 1'b0);
		check_value("x32_penable idle", x32_penable, 1'b0);
		check_value("x64_psel idle", x64_psel, 1'b0);
		check_value("x64_penable idle", x64_penable, 1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// FMC host

	task automatic idle(int n);
		repeat (n) @(negedge apb_x32);
	endtask

	// Address cycle with ADV# low for one cycle
	task automatic addr_phase(fmc_apb_pkg::addr_t addr, logic rd);
		@(negedge apb_x32);
		fmc_cs_n    = 1'b0;
		fmc_nl_nadv = 1'b0;
		fmc_nwe     = rd;
		fmc_nbl     = 2'b00;
		fmc_a_hi    = addr[26:17];
		fmc_ad_in   = addr[16:1];
	endtask

	task automatic end_cycle();
		@(negedge apb_x32);
		fmc_cs_n    = 1'b1;
		fmc_nl_nadv = 1'b1;
		fmc_nwe     = 1'b1;
		fmc_nbl     = 2'b11;
	endtask

	task automatic write_cycle(fmc_apb_pkg::addr_t addr, logic [63:0] data, logic [7:0] strb);
		logic is64;
		int   halves;
		int   lane;
		is64   = addr >= BASE_X64;
		halves = is64 ? 4 : 2;
		addr_phase(addr, 1'b0);
		for (int k = 0; k < halves; k++) begin
			lane = lane_of(is64, k);
			@(negedge apb_x32);
			fmc_nl_nadv = 1'b1;
			fmc_ad_in   = data[16*lane +: 16];
			fmc_nbl     = ~strb[2*lane +: 2];
			// Hold the beat until an edge with WAIT# high
			#1;
			if (k == 0)
				check_value("fmc_ad_oe during write", fmc_ad_oe, 1'b0);
			while (!fmc_nwait) begin
				@(negedge apb_x32);
				#1;
			end
		end
		end_cycle();
		for (int b = 0; b < 2 * halves; b++) begin
			if (strb[b])
				store_byte(fmc_apb_pkg::addr_t'(addr + b), data[8*b +: 8]);
		end
	endtask

	// Aborted reads must come back as zero
	task automatic read_check(fmc_apb_pkg::addr_t addr, logic aborted);
		logic        is64;
		int          halves;
		int          k;
		int          lane;
		logic [15:0] exp;
		is64   = addr >= BASE_X64;
		halves = is64 ? 4 : 2;
		k      = 0;
		addr_phase(addr, 1'b1);
		while (k < halves) begin
			@(negedge apb_x32);
			fmc_nl_nadv = 1'b1;
			#1;
			if (fmc_nwait) begin
				lane = lane_of(is64, k);
				exp  = {model_byte(fmc_apb_pkg::addr_t'(addr + 2*lane + 1)),
					model_byte(fmc_apb_pkg::addr_t'(addr + 2*lane))};
				if (aborted)
					exp = 16'h0;
				if (k == 0)
					check_value("fmc_ad_oe during read", fmc_ad_oe, 1'b1);
				check_value($sformatf("read 0x%07h half %0d", addr, k), fmc_ad_out, exp);
				k++;
			end
		end
		end_cycle();
		// The latest setup cycle on the target segment carried this read
		if (is64) begin
			check_value("x64_paddr on read", setup_addr_x64, addr);
			check_value("x64_pwrite on read", setup_write_x64, 1'b0);
		end else begin
			check_value("x32_paddr on read", setup_addr_x32, addr);
			check_value("x32_pwrite on read", setup_write_x32, 1'b0);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		rst_n       = 1'b0;
		fmc_cs_n    = 1'b1;
		fmc_nl_nadv = 1'b1;
		fmc_nwe     = 1'b1;
		fmc_nbl     = 2'b11;
		fmc_a_hi    = '0;
		fmc_ad_in   = '0;
		stall_x32   = 1'b0;
		stall_x64   = 1'b0;
		test_num    = 0;
		checks      = 0;
		errors      = 0;
		mark_checks = 0;
		mark_errors = 0;
		cycle_cnt   = 0;

		// Idle levels from the first reset edge on
		for (int c = 0; c < RESET_CYCLES; c++) begin
			@(negedge apb_x32);
			if (c > 0)
				idle_checks();
		end
		rst_n = 1'b1;
		idle(3);
		idle_checks();
		test_done("reset state");

		for (int i = 0; i < 25; i++) begin
			addr_a = rand_addr(1'b0);
			data_a = {rand_word(), rand_word()};
			write_cycle(addr_a, data_a, 8'h0f);
			idle($random(seed) & 3);
			read_check(addr_a, 1'b0);
			idle($random(seed) & 3);
		end
		test_done("32-bit write and read");

		for (int i = 0; i < 25; i++) begin
			addr_a = rand_addr(1'b1);
			data_a = {rand_word(), rand_word()};
			write_cycle(addr_a, data_a, 8'hff);
			idle($random(seed) & 3);
			read_check(addr_a, 1'b0);
			idle($random(seed) & 3);
		end
		test_done("64-bit write and read");

		// Random NBL# per beat on both segments
		for (int i = 0; i < 20; i++) begin
			addr_a = rand_addr(1'($random(seed)));
			data_a = {rand_word(), rand_word()};
			write_cycle(addr_a, data_a, 8'($random(seed)));
			idle($random(seed) & 3);
			read_check(addr_a, 1'b0);
		end
		test_done("byte strobes");

		// No idle gaps so the host runs into a busy requester and stalls
		for (int i = 0; i < 10; i++) begin
			swap   = 1'($random(seed));
			addr_a = rand_addr(swap);
			addr_b = rand_addr(!swap);
			data_a = {rand_word(), rand_word()};
			data_b = {rand_word(), rand_word()};
			write_cycle(addr_a, data_a, 8'hff);
			write_cycle(addr_b, data_b, 8'hff);
			read_check(addr_a, 1'b0);
			read_check(addr_b, 1'b0);
		end
		test_done("back-to-back cycles");

		// 64-bit completer stays silent until the abort and then recovers
		@(negedge apb_x32);
		stall_x64 = 1'b1;
		read_check(rand_addr(1'b1), 1'b1);
		@(negedge apb_x32);
		stall_x64 = 1'b0;
		addr_a = rand_addr(1'b1);
		data_a = {rand_word(), rand_word()};
		write_cycle(addr_a, data_a, 8'hff);
		read_check(addr_a, 1'b0);
		test_done("stuck abort");

		$display("Totals: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- fmc_apb_bridge.f
logic/fmc_apb_pkg.sv
logic/apb_requester.sv
logic/fmc_cycle_decode.sv
logic/fmc_read_return.sv
logic/fmc_apb_bridge.sv
verif/apb_mem_completer.sv
verif/fmc_apb_bridge_tb.sv

//--- Makefile
# Verilator simulation of the FMC to APB bridge

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 \
		-f fmc_apb_bridge.f --top-module fmc_apb_bridge_tb \
		-o fmc_apb_bridge_sim
	@out="$$(./obj_dir/fmc_apb_bridge_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir
